// ==== Bender.yml ====
package:
  name: sound_level_meter

sources:
  - src/board_pkg.sv
  - src/inmp441_mic_i2s_receiver.sv
  - src/tm1638_board_controller.sv
  - src/sound_level_top.sv
  - src/board_specific_top.sv
  - target: test
    files:
      - tb/tb_panel_models.sv
      - tb/tb_board_specific_top.sv

// ==== build.f ====
src/board_pkg.sv
src/inmp441_mic_i2s_receiver.sv
src/tm1638_board_controller.sv
src/sound_level_top.sv
src/board_specific_top.sv
tb/tb_panel_models.sv
tb/tb_board_specific_top.sv

// ==== src/board_pkg.sv ====
package board_pkg;

    // ------------------------------
    // Panel and microphone widths
    // ------------------------------

    localparam int w_tm_key   = 8;   // TM1638 key inputs
    localparam int w_tm_led   = 8;   // Red LEDs above the digits
    localparam int w_tm_digit = 8;   // Seven-segment positions
    localparam int w_mic      = 24;  // INMP441 word width

    // ------------------------------
    // Bundles
    // ------------------------------

    typedef struct packed
    {
        logic                      valid;  // Strobe, one clk per left word
        logic signed [w_mic - 1:0] value;  // Held until the next strobe
    } mic_sample_t;

    // Whole panel image, 72 bits
    typedef struct packed
    {
        logic [w_tm_digit * 8 - 1:0] hgfedcba;  // Digit 0 in the low byte
        logic [w_tm_led       - 1:0] led;
    } tm_panel_t;

    // ------------------------------
    // TM1638 controller
    // ------------------------------

    typedef enum logic [2:0]
    {
        TM_IDLE,      // Latch panel, start frame
        TM_CMD_MODE,  // Write with auto increment
        TM_CMD_ADDR,  // Start address
        TM_DATA,      // 16 display bytes
        TM_CMD_ON,    // Display on, full brightness
        TM_CMD_READ,  // Key scan request
        TM_KEYS,      // 4 key bytes in
        TM_GAP        // Pause before the next frame
    } tm_state_t;

    typedef enum logic [7:0]
    {
        TM_WRITE_AUTO = 8'h40,
        TM_READ_KEYS  = 8'h42,
        TM_ADDR_0     = 8'hC0,
        TM_DISPLAY_ON = 8'h8F
    } tm_cmd_e;

endpackage

// ==== src/board_specific_top.sv ====
`timescale 1ns/1ps

module board_specific_top
# (
    parameter clk_mhz = 27,
              w_key   = 2,   // The last key is the reset
              w_led   = 6,
              w_gpio  = 9
)
(
    input                     CLK,

    input  [w_key    - 1:0]   KEY,
    output [w_led    - 1:0]   LED,

    inout  wire [w_gpio - 1:0] GPIO
);

    import board_pkg::*;

    // ------------------------------
    // Reset and keys
    // ------------------------------

    localparam int w_board_key = w_key - 1;  // Without the reset key
    localparam int w_top_key   = 2;          // Clear and hold

    wire rst_n = KEY [w_key - 1];            // Active low on the board

    logic [w_tm_key   - 1:0] tm_key;
    logic [w_top_key  - 1:0] top_key;
    logic [w_tm_led   - 1:0] top_led;
    logic [w_tm_digit * 8 - 1:0] abcdefgh;

    tm_panel_t   panel;
    mic_sample_t mic_sample;

    // Panel keys and board keys act the same
    always_comb
    begin
        top_key = tm_key [w_top_key - 1:0];

        for (int i = 0; i < w_board_key && i < w_top_key; i++)
            top_key [i] |= ~ KEY [i];
    end

    // ------------------------------
    // Application
    // ------------------------------

    sound_level_top i_top
    (
        .clk      ( CLK        ),
        .rst_n    ( rst_n      ),
        .key      ( top_key    ),
        .sample   ( mic_sample ),
        .abcdefgh ( abcdefgh   ),
        .led      ( top_led    )
    );

    assign LED = ~ top_led [w_led - 1:0];   // Board LEDs are active low

    // Panel wants segment a in bit 0
    always_comb
    begin
        for (int i = 0; i < w_tm_digit * 8; i++)
            panel.hgfedcba [i] = abcdefgh [(i / 8) * 8 + 7 - i % 8];

        panel.led = top_led;
    end

    // ------------------------------
    // Peripherals
    // ------------------------------

    tm1638_board_controller
    # (
        .clk_mhz ( clk_mhz )
    )
    i_tm1638
    (
        .clk      ( CLK      ),
        .rst_n    ( rst_n    ),  // Never reset by its own keys
        .panel    ( panel    ),
        .keys     ( tm_key   ),
        .sio_clk  ( GPIO [0] ),
        .sio_stb  ( GPIO [1] ),
        .sio_data ( GPIO [2] )
    );

    inmp441_mic_i2s_receiver
    # (
        .clk_mhz ( clk_mhz )
    )
    i_microphone
    (
        .clk    ( CLK        ),
        .rst_n  ( rst_n      ),
        .sck    ( GPIO [3]   ),
        .ws     ( GPIO [4]   ),
        .sd     ( GPIO [6]   ),
        .sample ( mic_sample )
    );

    assign GPIO [5] = 1'b0;  // L/R select, left channel
    assign GPIO [7] = 1'b1;  // VCC
    assign GPIO [8] = 1'b0;  // GND

endmodule

// ==== src/inmp441_mic_i2s_receiver.sv ====
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
# (
    parameter clk_mhz = 50
)
(
    input                         clk,
    input                         rst_n,

    output logic                  sck,
    output logic                  ws,
    input                         sd,

    output board_pkg::mic_sample_t sample
);

    import board_pkg::*;

    // ------------------------------
    // Bit clock divider
    // ------------------------------

    localparam int half_period = clk_mhz / 6 > 0 ? clk_mhz / 6 : 1;
    localparam int w_div       = $clog2 (half_period + 1);

    logic [w_div - 1:0] div_cnt;
    logic [        5:0] bit_cnt;    // sck periods within the 64-period frame
    logic [w_mic - 1:0] shift;
    logic [w_mic - 1:0] value_q;
    logic               valid_q;

    wire tick     = div_cnt == w_div' (half_period - 1);
    wire sck_rise = tick & ~ sck;
    wire sck_fall = tick &   sck;

    // Last LSB period of the left half ends here
    wire word_end = sck_fall & (bit_cnt == 6'd24);

    // Bits 1..24 of the left half carry the word, bit 0 is the I2S delay slot
    wire data_bit = ~ ws & (bit_cnt >= 6'd1) & (bit_cnt <= 6'd24);

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            if (tick)
                sck <= ~ sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;  // ws follows bit_cnt [5]

            valid_q <= word_end;
        end
    end

    // ------------------------------
    // Sample capture
    // ------------------------------

    always_ff @ (posedge clk)
    begin
        if (sck_rise && data_bit)
            shift <= { shift [w_mic - 2:0], sd };  // MSB first

        if (word_end)
            value_q <= shift;
    end

    assign ws           = bit_cnt [5];  // Low for the left channel
    assign sample.valid = valid_q;
    assign sample.value = value_q;

endmodule

// ==== src/sound_level_top.sv ====
`timescale 1ns/1ps

module sound_level_top
(
    input                                          clk,
    input                                          rst_n,

    input        [                          1:0]   key,
    input  board_pkg::mic_sample_t                 sample,

    output logic [board_pkg::w_tm_digit * 8 - 1:0] abcdefgh,
    output logic [board_pkg::w_tm_led     - 1:0]   led
);

    import board_pkg::*;

    localparam int w_hex_digits = w_mic / 4;  // 6 nibbles of the peak

    // ------------------------------
    // Peak tracking
    // ------------------------------

    logic [w_mic - 1:0] peak;
    logic [w_mic - 1:0] magnitude;

    // Most negative word maps to 2 ** 23, still fits unsigned
    assign magnitude = sample.value [w_mic - 1] ? $unsigned (- sample.value)
                                                : $unsigned (sample.value);

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
            peak <= '0;
        else if (key [0])
            peak <= '0;                          // Clear wins over hold
        else if (sample.valid && ! key [1] && magnitude > peak)
            peak <= magnitude;
    end

    // ------------------------------
    // Hex display
    // ------------------------------

    function automatic logic [7:0] hex_font (input logic [3:0] nibble);
        case (nibble)
        4'h0:    hex_font = 8'b1111_1100;
        4'h1:    hex_font = 8'b0110_0000;
        4'h2:    hex_font = 8'b1101_1010;
        4'h3:    hex_font = 8'b1111_0010;
        4'h4:    hex_font = 8'b0110_0110;
        4'h5:    hex_font = 8'b1011_0110;
        4'h6:    hex_font = 8'b1011_1110;
        4'h7:    hex_font = 8'b1110_0000;
        4'h8:    hex_font = 8'b1111_1110;
        4'h9:    hex_font = 8'b1111_0110;
        4'ha:    hex_font = 8'b1110_1110;
        4'hb:    hex_font = 8'b0011_1110;
        4'hc:    hex_font = 8'b1001_1100;
        4'hd:    hex_font = 8'b0111_1010;
        4'he:    hex_font = 8'b1001_1110;
        default: hex_font = 8'b1000_1110;
        endcase
    endfunction

    always_comb
    begin
        abcdefgh = '0;                           // Upper digits stay blank

        for (int i = 0; i < w_hex_digits; i++)
            abcdefgh [i * 8 +: 8] = hex_font (peak [i * 4 +: 4]);
    end

    // ------------------------------
    // LED bar
    // ------------------------------

    // LED i lights once the peak reaches 2 ** (16 + i)
    always_comb
    begin
        for (int i = 0; i < w_tm_led; i++)
            led [i] = | (peak >> (16 + i));
    end

endmodule

// ==== src/tm1638_board_controller.sv ====
`timescale 1ns/1ps

module tm1638_board_controller
# (
    parameter clk_mhz = 50
)
(
    input                                   clk,
    input                                   rst_n,

    input  board_pkg::tm_panel_t            panel,
    output logic [board_pkg::w_tm_key - 1:0] keys,

    output logic                            sio_clk,
    output logic                            sio_stb,
    inout  wire                             sio_data
);

    import board_pkg::*;

    // ------------------------------
    // Serial bit rate
    // ------------------------------

    localparam int half_period = clk_mhz / 2 > 0 ? clk_mhz / 2 : 1;
    localparam int w_div       = $clog2 (half_period + 1);
    localparam int w_sel       = $clog2 (w_tm_digit);

    logic [w_div - 1:0] div_cnt;

    wire tick = div_cnt == w_div' (half_period - 1);

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
            div_cnt <= '0;
        else
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end

    // ------------------------------
    // Frame state
    // ------------------------------

    tm_state_t           state;
    tm_panel_t           panel_q;     // Frame snapshot
    logic [         3:0] half_cnt;    // Even on rising sio_clk, odd on falling
    logic [         3:0] byte_idx;    // Data, key or gap counter
    logic                stb_wait;    // stb held high for one half period
    logic                data_oe;
    logic [         7:0] shift_out;
    logic [         7:0] shift_in;
    logic [w_tm_key-1:0] key_buf;
    logic [w_tm_key-1:0] key_next;
    logic [         3:0] data_idx;
    logic [w_sel   -1:0] data_digit;
    logic [         7:0] data_byte;

    // Next display byte with segments at even addresses and LED at odd ones
    assign data_idx = (state == TM_DATA) ? byte_idx + 4'd1 : 4'd0;

    always_comb
    begin
        data_digit = data_idx [w_sel:1];

        if (data_idx [0])
            data_byte = { 7'b0, panel_q.led [data_digit] };
        else
            data_byte = panel_q.hgfedcba [data_digit * 8 +: 8];
    end

    // Key byte n carries key n in bit 0 and key n + 4 in bit 4
    always_comb
    begin
        key_next                        = key_buf;
        key_next [{ 1'b0, byte_idx [1:0] }] = shift_in [0];
        key_next [{ 1'b1, byte_idx [1:0] }] = shift_in [4];
    end

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
        begin
            state     <= TM_IDLE;
            sio_clk   <= 1'b0;
            sio_stb   <= 1'b1;
            half_cnt  <= '0;
            byte_idx  <= '0;
            stb_wait  <= 1'b0;
            data_oe   <= 1'b1;
            shift_out <= 8'hff;
            key_buf   <= '0;
            keys      <= '0;
        end
        else if (tick)
        begin
            if (state == TM_IDLE)
            begin
                sio_stb   <= 1'b0;
                half_cnt  <= '0;
                shift_out <= TM_WRITE_AUTO;
                state     <= TM_CMD_MODE;
            end
            else if (state == TM_GAP)
            begin
                byte_idx <= byte_idx + 1'b1;

                if (byte_idx == 4'd15)
                    state <= TM_IDLE;
            end
            else if (stb_wait)
            begin
                sio_stb  <= 1'b0;
                stb_wait <= 1'b0;
            end
            else if (! half_cnt [0])
            begin
                sio_clk  <= 1'b1;                 // Panel samples here
                half_cnt <= half_cnt + 1'b1;
            end
            else
            begin
                sio_clk  <= 1'b0;                 // Data moves here
                half_cnt <= half_cnt + 1'b1;

                if (half_cnt != 4'd15)
                    shift_out <= shift_out >> 1;  // LSB first
                else
                begin
                    case (state)
                    TM_CMD_MODE:
                    begin
                        sio_stb   <= 1'b1;
                        stb_wait  <= 1'b1;
                        shift_out <= TM_ADDR_0;
                        state     <= TM_CMD_ADDR;
                    end
                    TM_CMD_ADDR:
                    begin
                        byte_idx  <= '0;
                        shift_out <= data_byte;
                        state     <= TM_DATA;
                    end
                    TM_DATA:
                    begin
                        if (byte_idx == 4'd15)
                        begin
                            sio_stb   <= 1'b1;
                            stb_wait  <= 1'b1;
                            shift_out <= TM_DISPLAY_ON;
                            state     <= TM_CMD_ON;
                        end
                        else
                        begin
                            byte_idx  <= byte_idx + 1'b1;
                            shift_out <= data_byte;
                        end
                    end
                    TM_CMD_ON:
                    begin
                        sio_stb   <= 1'b1;
                        stb_wait  <= 1'b1;
                        shift_out <= TM_READ_KEYS;
                        state     <= TM_CMD_READ;
                    end
                    TM_CMD_READ:
                    begin
                        byte_idx <= '0;
                        data_oe  <= 1'b0;         // Panel drives the line now
                        state    <= TM_KEYS;
                    end
                    default:                      // TM_KEYS
                    begin
                        key_buf  <= key_next;
                        byte_idx <= byte_idx + 1'b1;

                        if (byte_idx == 4'd3)
                        begin
                            sio_stb  <= 1'b1;
                            data_oe  <= 1'b1;
                            keys     <= key_next; // End of frame
                            byte_idx <= '0;
                            state    <= TM_GAP;
                        end
                    end
                    endcase
                end
            end
        end
    end

    // ------------------------------
    // Snapshot and key input
    // ------------------------------

    always_ff @ (posedge clk)
    begin
        if (tick && state == TM_IDLE)
            panel_q <= panel;

        if (tick && state == TM_KEYS && ! half_cnt [0])
            shift_in <= { sio_data, shift_in [7:1] };
    end

    assign sio_data = data_oe ? shift_out [0] : 1'bz;

endmodule

// ==== tb/tb_board_specific_top.sv ====
`timescale 1ns/1ps

module tb_board_specific_top;

    localparam int clk_mhz    = 50;
    localparam int clk_period = 20;
    localparam int n_fixed    = 11;
    localparam int n_random   = 12;
    localparam int n_rows     = n_fixed + n_random;

    // 24 bytes of 16 half periods, idle, three stb pauses, 16 gap ticks
    localparam longint tm_frame_ns  = 404 * (clk_mhz / 2) * clk_period;
    localparam longint mic_frame_ns = 64 * 2 * (clk_mhz / 6) * clk_period;
    localparam longint watchdog_ns  = n_rows * 3 * tm_frame_ns + mic_frame_ns
                                    + 8 * clk_period;

    typedef struct packed
    {
        logic [23:0] value;      // Mic word
        logic [ 7:0] mask;       // Panel keys
        logic        board_key;  // Low KEY[0] clears the peak
    } row_t;

    logic        clk;
    logic [ 1:0] key;
    wire  [ 5:0] led;
    wire  [ 8:0] gpio;
    logic [23:0] mic_word;
    logic [ 7:0] key_mask;
    logic [63:0] segs;
    logic [ 7:0] panel_led;
    int          frames;
    int          words_sent;
    row_t        rows  [n_rows];
    string       names [n_rows];
    logic [23:0] ref_peak;
    logic [23:0] cur_word;

    board_specific_top
    # (
        .clk_mhz ( clk_mhz ),
        .w_key   ( 2       ),
        .w_led   ( 6       ),
        .w_gpio  ( 9       )
    )
    board_specific_top_i
    (
        .CLK  ( clk  ),
        .KEY  ( key  ),
        .LED  ( led  ),
        .GPIO ( gpio )
    );

    tb_mic_source mic_model
    (
        .sck        ( gpio [3]   ),
        .ws         ( gpio [4]   ),
        .word       ( mic_word   ),
        .sd         ( gpio [6]   ),
        .words_sent ( words_sent )
    );

    tb_tm1638_panel panel_model
    (
        .sio_clk  ( gpio [0]  ),
        .sio_stb  ( gpio [1]  ),
        .sio_data ( gpio [2]  ),
        .key_mask ( key_mask  ),
        .segs     ( segs      ),
        .leds     ( panel_led ),
        .frames   ( frames    )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~ clk;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the panel stopped refreshing or the mic words stopped");
        $display("Verification failed");
        $fatal(1);
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [23:0] abs_value (input logic [23:0] v);
        return v [23] ? - v : v;  // 800000h stays 800000h
    endfunction

    function automatic logic [23:0] step_peak (input logic [23:0] peak, input logic [23:0] v,
                                               input logic clear, input logic hold);
        logic [23:0] mag;
        mag = abs_value (v);
        if (clear)
            return '0;
        if (hold || mag <= peak)
            return peak;
        return mag;
    endfunction

    // Segment a in bit 0 as the panel receives it
    function automatic logic [7:0] seg_code (input logic [3:0] nibble);
        logic [7:0] font [16];
        font = '{ 8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                  8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71 };
        return font [nibble];
    endfunction

    function automatic logic [63:0] expected_segs (input logic [23:0] peak);
        logic [63:0] segs_v;
        segs_v = '0;                   // Digits 6 and 7 blank
        for (int i = 0; i < 6; i++)
            segs_v [i * 8 +: 8] = seg_code (peak [i * 4 +: 4]);
        return segs_v;
    endfunction

    function automatic logic [7:0] expected_bar (input logic [23:0] peak);
        logic [7:0] bar;
        for (int i = 0; i < 8; i++)
            bar [i] = { 8'b0, peak } >= (32'd1 << (16 + i));
        return bar;
    endfunction

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic check (input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic wait_frames (input int n);
        int target;
        target = frames + n;
        while (frames < target)
            @(negedge clk);
    endtask

    task automatic wait_words (input int n);
        int target;
        target = words_sent + n;
        while (words_sent < target)
            @(negedge clk);
    endtask

    task automatic set_row (input int r, input logic [23:0] v, input logic [7:0] m,
                            input logic k, input string n);
        rows [r].value     = v;
        rows [r].mask      = m;
        rows [r].board_key = k;
        names [r]          = n;
    endtask

    task automatic fill_table ();
        int unsigned rnd;
        int unsigned sh;
        set_row ( 0, 24'h000000, 8'h00, 1'b1, "reset");
        set_row ( 1, 24'h012345, 8'h00, 1'b1, "positive");
        set_row ( 2, 24'hf54322, 8'h00, 1'b1, "negative");  // -0ABCDEh
        set_row ( 3, 24'h001234, 8'h00, 1'b1, "smaller");
        set_row ( 4, 24'h000000, 8'h01, 1'b1, "panel_clear");
        set_row ( 5, 24'h000f00, 8'h00, 1'b1, "after_clear");
        set_row ( 6, 24'h3f0000, 8'h02, 1'b1, "hold");
        set_row ( 7, 24'h000100, 8'h00, 1'b1, "release");
        set_row ( 8, 24'h000000, 8'h00, 1'b0, "board_clear");
        set_row ( 9, 24'h800000, 8'h00, 1'b1, "most_negative");
        set_row (10, 24'h000000, 8'h00, 1'b0, "clear_before_random");
        for (int i = 0; i < n_random; i++)
        begin
            rnd = $urandom;
            sh  = $urandom % 16;   // Spread the magnitudes
            rnd = rnd >> sh;
            set_row (n_fixed + i, rnd [23:0], 8'h00, 1'b1, $sformatf("random_%0d", i));
        end
    endtask

    task automatic apply_row (input int r);
        row_t row;
        logic clear;
        logic hold;
        row   = rows [r];
        clear = row.mask [0] | ~ row.board_key;
        hold  = row.mask [1];

        // Keys change first so the word already on the line sees them
        @(negedge clk);
        key [0] = row.board_key;
        if (row.mask != key_mask)
        begin
            key_mask = row.mask;
            wait_frames (2);       // Scan after the change reaches keys
        end
        wait_words (2);
        ref_peak = step_peak (ref_peak, cur_word, clear, hold);

        @(negedge clk);
        mic_word = row.value;
        cur_word = row.value;
        wait_words (2);
        ref_peak = step_peak (ref_peak, row.value, clear, hold);

        wait_frames (2);           // One frame sampled after the update
        @(negedge clk);
        check ({ names [r], " digits" }, expected_segs (ref_peak), segs);
        check ({ names [r], " panel leds" }, 64'(expected_bar (ref_peak)), 64'(panel_led));
        check ({ names [r], " board leds" }, 64'(~ expected_bar (ref_peak) & 8'h3f), 64'(led));
        check ({ names [r], " power pins" }, 64'(3'b010),
               64'({ gpio [8], gpio [7], gpio [5] }));
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial
    begin
        int unsigned seed;
        int unsigned first;
        key      = 2'b01;          // Reset held low and KEY[0] released
        key_mask = '0;
        mic_word = '0;
        cur_word = '0;
        ref_peak = '0;
        seed     = 32'hf56;
        first    = $urandom(seed);
        fill_table ();

        repeat (8) @(negedge clk);
        key [1] = 1'b1;

        for (int r = 0; r < n_rows; r++)
            apply_row (r);

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tb/tb_panel_models.sv ====
`timescale 1ns/1ps

// INMP441 stand-in, shifts one 24-bit word per frame on the left channel
module tb_mic_source
(
    input               sck,
    input               ws,
    input        [23:0] word,
    output logic        sd,
    output int          words_sent
);

    logic        prev_ws;
    logic [23:0] word_q;
    int          pos;       // sck period within the frame

    initial
    begin
        prev_ws    = 1'b1;
        word_q     = '0;
        pos        = 100;   // No frame seen yet
        sd         = 1'b0;
        words_sent = 0;
    end

    always @(posedge sck)
    begin
        if (!ws && prev_ws)
        begin
            pos    = 0;      // Frame start, latch the word for this frame
            word_q = word;
        end
        else
            pos = pos + 1;

        if (!ws && pos == 25)
            words_sent = words_sent + 1;  // LSB taken, valid already pulsed

        prev_ws = ws;
    end

    // Period pos + 1 carries bit 23 - pos
    always @(negedge sck)
        sd = (pos < 24) ? word_q [23 - pos] : 1'b0;

endmodule

// TM1638 stand-in, decodes the display bytes and answers the key scan
module tb_tm1638_panel
(
    input               sio_clk,
    input               sio_stb,
    inout  wire         sio_data,
    input        [ 7:0] key_mask,
    output logic [63:0] segs,
    output logic [ 7:0] leds,
    output int          frames
);

    logic [7:0] mem [0:15];
    logic [7:0] shift;
    logic [7:0] cmd;
    logic [7:0] mask_q;     // Keys frozen for one scan
    logic       reading;
    logic       drive_en;
    logic       drive_bit;
    int         bit_cnt;
    int         byte_cnt;
    int         addr;
    int         read_cnt;
    int         rd_byte;
    int         rd_bit;

    assign sio_data = drive_en ? drive_bit : 1'bz;

    initial
    begin
        reading   = 1'b0;
        drive_en  = 1'b0;
        drive_bit = 1'b0;
        segs      = '0;
        leds      = '0;
        frames    = 0;
        bit_cnt   = 0;
        byte_cnt  = 0;
        addr      = 0;
        read_cnt  = 0;
    end

    always @(negedge sio_stb)
    begin
        bit_cnt  = 0;
        byte_cnt = 0;
    end

    always @(posedge sio_clk)
    begin
        if (!sio_stb && reading)
            read_cnt = read_cnt + 1;
        else if (!sio_stb)
        begin
            shift   = { sio_data, shift [7:1] };  // LSB first
            bit_cnt = bit_cnt + 1;

            if (bit_cnt == 8)
            begin
                bit_cnt = 0;

                if (byte_cnt == 0)
                begin
                    cmd  = shift;
                    addr = 0;

                    if (shift == 8'h42)
                    begin
                        reading  = 1'b1;
                        read_cnt = 0;
                        mask_q   = key_mask;
                    end
                end
                else if (cmd == 8'hc0 && addr < 16)
                begin
                    mem [addr] = shift;
                    addr       = addr + 1;
                end

                byte_cnt = byte_cnt + 1;
            end
        end
    end

    // Key byte n: bit 0 is key n, bit 4 is key n + 4
    always @(negedge sio_clk)
    begin
        if (reading && !sio_stb)
        begin
            rd_byte   = read_cnt / 8;
            rd_bit    = read_cnt % 8;
            drive_en  = 1'b1;
            drive_bit = 1'b0;

            if (rd_byte < 4 && rd_bit == 0)
                drive_bit = mask_q [rd_byte];
            else if (rd_byte < 4 && rd_bit == 4)
                drive_bit = mask_q [rd_byte + 4];
        end
    end

    // stb rising after the key bytes closes the frame
    always @(posedge sio_stb)
    begin
        if (reading)
        begin
            reading  = 1'b0;
            drive_en = 1'b0;

            for (int i = 0; i < 8; i++)
            begin
                segs [i * 8 +: 8] = mem [2 * i];
                leds [i]          = mem [2 * i + 1][0];
            end

            frames = frames + 1;
        end
    end

endmodule
